//--- Makefile
VERILATOR ?= verilator
TOP       ?= husky_lite_tb
RTL_TOP   ?= husky_lite_top
FILELIST  ?= husky_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/husky_lite_config.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/husky_lite_sva.sv
`include "husky_lite_config.svh"

module husky_sva (
   input logic                        clk_usb_buf,
   input logic                        rst_n_i,
   input logic                        bus_read,
   input logic                        bus_write,
   input logic                        usb_cen_i,
   input logic                        usb_data_oe_o,
   input logic                        trig_out_o,
   input logic [`TARGET_IO_WIDTH-1:0] trig_mask
);
   timeunit 1ns;
   timeprecision 100ps;

   no_rd_wr_overlap: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !(bus_read && bus_write))
      else $error("register bus read and write pulses overlap");

   // output enable only while the chip is selected
   oe_needs_cen: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      usb_cen_i |-> !usb_data_oe_o)
      else $error("usb data output enabled with chip enable high");

   // trigger is registered, so it follows the mask one cycle later
   no_trig_without_mask: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      (trig_mask == '0) |=> !trig_out_o)
      else $error("trigger output high with an empty mask");

endmodule

bind husky_lite_top husky_sva husky_sva_inst (
   .clk_usb_buf   (clk_usb_buf),
   .rst_n_i       (rst_n_i),
   .bus_read      (reg_bus.read),
   .bus_write     (reg_bus.write),
   .usb_cen_i     (usb_cen_i),
   .usb_data_oe_o (usb_data_oe_o),
   .trig_out_o    (trig_out_o),
   .trig_mask     (trigger_ctrl_inst.mask_q)
);

//--- dv/husky_lite_tb.sv
`include "husky_lite_config.svh"

module husky_lite_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import husky_lite_pkg::*;

   logic                        clk_usb_buf;
   logic                        rst_n_i;
   reg_addr_t                   usb_addr_i;
   reg_data_t                   usb_data_i;
   reg_data_t                   usb_data_o;
   logic                        usb_data_oe_o;
   logic                        usb_rdn_i;
   logic                        usb_wrn_i;
   logic                        usb_cen_i;
   logic [`TARGET_IO_WIDTH-1:0] target_io_i;
   logic                        pll_status_i;
   logic                        trig_out_o;
   logic                        target_poweron_o;
   logic                        led_adc_o;
   logic                        led_armed_o;
   logic                        led_cap_o;
   integer                      seed = 43919;
   logic [3:0]                  held_io;   // io pattern held during the bursts

   husky_lite_top husky_lite_top_inst (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #20 clk_usb_buf = ~clk_usb_buf;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
      if (actual !== expected) begin
         fail_run($sformatf("ERROR at %0t ns: %s expected 0x%0h got 0x%0h",
                            $time, what, expected, actual));
      end
   endtask

   task automatic next_cycle;   // inputs change 2 ns after the edge
      @(posedge clk_usb_buf);
      #2;
   endtask

   task automatic usb_write(input reg_addr_t addr, input reg_data_t data);
      next_cycle();
      usb_addr_i = addr;
      usb_data_i = data;
      usb_cen_i  = 1'b0;
      usb_wrn_i  = 1'b0;
      repeat (4) next_cycle();
      usb_cen_i = 1'b1;
      usb_wrn_i = 1'b1;
      repeat (2) next_cycle();
   endtask

   task automatic usb_read(input reg_addr_t addr, output reg_data_t data);
      next_cycle();
      usb_addr_i = addr;
      usb_cen_i  = 1'b0;
      usb_rdn_i  = 1'b0;
      repeat (4) next_cycle();
      data = usb_data_o;   // stable from the third edge on
      check_eq(32'(usb_data_oe_o), 1, "output enable during read");
      usb_cen_i = 1'b1;
      usb_rdn_i = 1'b1;
      next_cycle();
      check_eq(32'(usb_data_oe_o), 0, "output enable after read");
      next_cycle();
   endtask

   // done set and armed cleared means the burst is over
   task automatic wait_capture_done;
      reg_data_t st;
      int        polls;
      polls = 0;
      usb_read(`ADDR_LA_STATUS, st);
      while (!(st[1] && !st[0])) begin
         if (polls == 20) fail_run("timeout waiting for the capture burst to finish");
         else begin
            polls++;
            usb_read(`ADDR_LA_STATUS, st);
         end
      end
   endtask

   function automatic logic trig_rule(input logic [3:0] io, input logic [3:0] mask,
                                      input logic and_mode);
      int n_mask;
      int n_high;
      n_mask = 0;
      n_high = 0;
      for (int b = 0; b < 4; b++) begin
         if (mask[b]) begin
            n_mask++;
            if (io[b]) n_high++;
         end
      end
      if (and_mode) return (n_mask > 0) && (n_high == n_mask);
      else return n_high > 0;
   endfunction

   task automatic test_register_readback;
      reg_data_t rd;
      usb_write(`ADDR_TRIG_CFG, 8'h13);
      usb_read(`ADDR_TRIG_CFG, rd);
      check_eq(32'(rd), 32'h13, "trigger config readback");
      usb_write(`ADDR_TARGET_PWR, 8'h01);
      check_eq(32'(target_poweron_o), 1, "target power on");
      usb_read(`ADDR_TARGET_PWR, rd);
      check_eq(32'(rd), 32'h01, "target power readback");
      usb_write(`ADDR_TARGET_PWR, 8'h00);
      check_eq(32'(target_poweron_o), 0, "target power off");
      usb_read(8'h55, rd);
      check_eq(32'(rd), 0, "unused address");
   endtask

   task automatic test_trigger_combine;
      logic [3:0] masks [2];
      logic [3:0] io;
      masks[0] = 4'b1010;   // OR mode
      masks[1] = 4'b0111;   // AND mode
      for (int m = 0; m < 2; m++) begin
         usb_write(`ADDR_TRIG_CFG, {3'b000, m[0], masks[m]});
         for (int i = 0; i < 16; i++) begin
            io = (i == 0) ? 4'hf : 4'($random(seed));
            target_io_i = io;
            repeat (2) next_cycle();
            check_eq(32'(trig_out_o), 32'(trig_rule(io, masks[m], m[0])), "trigger output");
         end
      end
   endtask

   task automatic test_capture_burst;
      reg_data_t rd;
      target_io_i = 4'h0;
      usb_write(`ADDR_TRIG_CFG, 8'h06);
      usb_write(`ADDR_LA_CTRL, 8'h01);
      check_eq(32'(led_armed_o), 1, "armed led after arm");
      check_eq(32'(led_cap_o), 0, "capture led while waiting for trigger");
      held_io = 4'($random(seed)) | 4'b0110;
      target_io_i = held_io;
      repeat (3) next_cycle();   // trigger, then capture, then led register
      check_eq(32'(led_cap_o), 1, "capture led during burst");
      wait_capture_done();
      check_eq(32'(led_armed_o), 0, "armed led after burst");
      check_eq(32'(led_cap_o), 0, "capture led after burst");
      usb_read(`ADDR_LA_STATUS, rd);
      check_eq(32'(rd), 32'h82, "status after burst");   // count 8, done
      for (int i = 0; i < 8; i++) begin
         usb_read(`ADDR_FIFO_READ, rd);
         check_eq(32'(rd), 32'({4'b0001, held_io}), "captured sample");
      end
      usb_read(`ADDR_LA_STATUS, rd);
      check_eq(32'(rd), 32'h06, "status after draining");
   endtask

   task automatic test_empty_pop;
      reg_data_t rd;
      usb_read(`ADDR_FIFO_READ, rd);
      check_eq(32'(rd), 0, "pop of empty fifo");
      usb_read(`ADDR_LA_STATUS, rd);
      check_eq(32'(rd[7:4]), 0, "count after empty pop");
      check_eq(32'(rd[2]), 1, "empty after empty pop");
   endtask

   task automatic test_overflow_led;
      reg_data_t rd;
      logic      led_start;
      int        waited;
      repeat (3) begin
         usb_write(`ADDR_LA_CTRL, 8'h01);
         wait_capture_done();
      end
      usb_read(`ADDR_LA_STATUS, rd);
      check_eq(32'(rd[3]), 1, "overflow error");
      check_eq(32'(rd[7:4]), 32'hf, "saturated count");
      check_eq(32'(husky_lite_top_inst.fifo_bus.count), 16, "fifo fill count");
      led_start = led_adc_o;
      waited = 0;
      while (led_adc_o == led_start) begin
         if (waited == 20) fail_run("led_adc_o did not flash within 20 cycles");
         else begin
            waited++;
            next_cycle();
         end
      end
      usb_write(`ADDR_LA_CTRL, 8'h02);
      check_eq(32'(led_adc_o), 32'(!pll_status_i), "led with pll locked");
      pll_status_i = 1'b0;
      next_cycle();
      check_eq(32'(led_adc_o), 32'(!pll_status_i), "led with pll unlocked");
      usb_read(`ADDR_LA_STATUS, rd);
      check_eq(32'(rd[3]), 0, "error after clear");
   endtask

   task automatic test_flush;
      reg_data_t rd;
      repeat (3) begin
         usb_read(`ADDR_FIFO_READ, rd);
         check_eq(32'(rd), 32'({4'b0001, held_io}), "sample before flush");
      end
      usb_write(`ADDR_LA_CTRL, 8'h04);
      usb_read(`ADDR_LA_STATUS, rd);
      check_eq(32'(rd[2]), 1, "empty after flush");
      check_eq(32'(rd[7:4]), 0, "count after flush");
   endtask

   initial begin
      rst_n_i      = 1'b0;
      usb_addr_i   = '0;
      usb_data_i   = '0;
      usb_rdn_i    = 1'b1;
      usb_wrn_i    = 1'b1;
      usb_cen_i    = 1'b1;
      target_io_i  = '0;
      pll_status_i = 1'b1;
      held_io      = '0;
      repeat (3) @(posedge clk_usb_buf);
      #2;
      rst_n_i = 1'b1;
      next_cycle();
      test_register_readback();
      test_trigger_combine();
      test_capture_burst();
      test_empty_pop();
      test_overflow_led();
      test_flush();
      $display("** PASS **");
      $finish;
   end

endmodule

//--- husky_lite.f
+incdir+rtl
rtl/husky_lite_pkg.sv
rtl/reg_bus_if.sv
rtl/capture_fifo_if.sv
rtl/usb_reg_bus.sv
rtl/trigger_ctrl.sv
rtl/la_capture.sv
rtl/capture_fifo.sv
rtl/led_status.sv
rtl/husky_lite_top.sv
dv/husky_lite_sva.sv
dv/husky_lite_tb.sv

//--- rtl/capture_fifo.sv
`include "husky_lite_config.svh"

module capture_fifo (
   input  logic           clk_usb_buf,
   input  logic           rst_n_i,
   capture_fifo_if.buffer fifo
);
   import husky_lite_pkg::*;

   localparam int PTR_W = $clog2(`FIFO_DEPTH);

   la_sample_t       mem [`FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   fifo_cnt_t        count_q;
   logic             error_q;
   logic             full;
   logic             push;
   logic             pop_ok;

   assign full   = (count_q == fifo_cnt_t'(`FIFO_DEPTH));
   assign push   = fifo.wr & ~full;        // writes while full are dropped
   assign pop_ok = fifo.pop & ~fifo.empty;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         error_q  <= 1'b0;
      end else begin
         if (fifo.flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
         end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop_ok})
               2'b10:   count_q <= count_q + 1'b1;
               2'b01:   count_q <= count_q - 1'b1;
               default: ;
            endcase
         end
         // overflow beats a clear in the same cycle
         if (fifo.wr && full) error_q <= 1'b1;
         else if (fifo.clear_err) error_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (push) mem[wr_ptr_q] <= fifo.wr_data;
   end

   assign fifo.empty = (count_q == '0);
   assign fifo.count = count_q;
   assign fifo.error = error_q;
   assign fifo.head  = fifo.empty ? '0 : mem[rd_ptr_q];

endmodule

//--- rtl/capture_fifo_if.sv
interface capture_fifo_if;
   import husky_lite_pkg::*;

   logic       wr;
   la_sample_t wr_data;
   logic       flush;
   logic       clear_err;
   logic       pop;
   la_sample_t head;      // zero while empty
   logic       empty;
   fifo_cnt_t  count;
   logic       error;     // sticky overflow

   modport producer (
      output wr, wr_data, flush, clear_err,
      input  empty, count, error
   );

   modport reader (
      output pop,
      input  head
   );

   modport buffer (
      input  wr, wr_data, flush, clear_err, pop,
      output head, empty, count, error
   );

endinterface

//--- rtl/husky_lite_config.svh
`ifndef HUSKY_LITE_CONFIG_SVH
`define HUSKY_LITE_CONFIG_SVH

// register bus geometry
`define REG_ADDR_WIDTH    8
`define REG_DATA_WIDTH    8
`define TARGET_IO_WIDTH   4
`define LA_SAMPLE_WIDTH   8

// register map
`define ADDR_TRIG_CFG     8'h10   // mask in 3:0, mode in 4
`define ADDR_TARGET_PWR   8'h11
`define ADDR_LA_CTRL      8'h20
`define ADDR_LA_STATUS    8'h21
`define ADDR_FIFO_READ    8'h30

// control and config bit positions
`define LA_ARM_BIT        0
`define LA_CLEAR_BIT      1
`define LA_FLUSH_BIT      2
`define TRIG_MODE_BIT     4       // 1 selects AND of masked lines

`define FIFO_DEPTH        16
`define FIFO_CNT_WIDTH    5
`define LA_BURST_LEN      8
`define FLASH_BIT         3       // led toggles every 2**FLASH_BIT cycles
`endif

//--- rtl/husky_lite_pkg.sv
`include "husky_lite_config.svh"

package husky_lite_pkg;

   typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;

   // io4..io1 in 3:0, trigger in 4, zeros above
   typedef logic [`LA_SAMPLE_WIDTH-1:0] la_sample_t;

   typedef logic [`FIFO_CNT_WIDTH-1:0] fifo_cnt_t;

endpackage

//--- rtl/husky_lite_top.sv
`include "husky_lite_config.svh"

module husky_lite_top (
   input  logic                        clk_usb_buf,
   input  logic                        rst_n_i,
   input  husky_lite_pkg::reg_addr_t   usb_addr_i,
   input  husky_lite_pkg::reg_data_t   usb_data_i,
   output husky_lite_pkg::reg_data_t   usb_data_o,
   output logic                        usb_data_oe_o,
   input  logic                        usb_rdn_i,
   input  logic                        usb_wrn_i,
   input  logic                        usb_cen_i,
   input  logic [`TARGET_IO_WIDTH-1:0] target_io_i,
   input  logic                        pll_status_i,
   output logic                        trig_out_o,
   output logic                        target_poweron_o,
   output logic                        led_adc_o,
   output logic                        led_armed_o,
   output logic                        led_cap_o
);

   husky_lite_pkg::reg_data_t trig_rdata;
   husky_lite_pkg::reg_data_t la_rdata;
   logic                      la_armed;
   logic                      la_capturing;

   reg_bus_if      reg_bus ();
   capture_fifo_if fifo_bus ();   // shared by sampler, fifo and usb reader

   usb_reg_bus usb_reg_bus_inst (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .trig_rdata_i  (trig_rdata),
      .la_rdata_i    (la_rdata),
      .bus           (reg_bus.host),
      .fifo          (fifo_bus.reader)
   );

   trigger_ctrl trigger_ctrl_inst (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n_i),
      .bus              (reg_bus.device),
      .target_io_i      (target_io_i),
      .rdata_o          (trig_rdata),
      .trig_o           (trig_out_o),
      .target_poweron_o (target_poweron_o)
   );

   la_capture la_capture_inst (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .bus         (reg_bus.device),
      .target_io_i (target_io_i),
      .trig_i      (trig_out_o),
      .rdata_o     (la_rdata),
      .armed_o     (la_armed),
      .capturing_o (la_capturing),
      .fifo        (fifo_bus.producer)
   );

   capture_fifo capture_fifo_inst (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .fifo        (fifo_bus.buffer)
   );

   led_status led_status_inst (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .error_i      (fifo_bus.error),
      .pll_status_i (pll_status_i),
      .armed_i      (la_armed),
      .capturing_i  (la_capturing),
      .led_adc_o    (led_adc_o),
      .led_armed_o  (led_armed_o),
      .led_cap_o    (led_cap_o)
   );

endmodule

//--- rtl/la_capture.sv
`include "husky_lite_config.svh"

module la_capture (
   input  logic                        clk_usb_buf,
   input  logic                        rst_n_i,
   reg_bus_if.device                   bus,
   input  logic [`TARGET_IO_WIDTH-1:0] target_io_i,
   input  logic                        trig_i,
   output husky_lite_pkg::reg_data_t   rdata_o,
   output logic                        armed_o,
   output logic                        capturing_o,
   capture_fifo_if.producer            fifo
);
   import husky_lite_pkg::*;

   localparam int         BURST_CNT_W = $clog2(`LA_BURST_LEN);
   localparam logic [1:0] ST_IDLE     = 2'd0;
   localparam logic [1:0] ST_ARMED    = 2'd1;
   localparam logic [1:0] ST_CAPTURE  = 2'd2;

   logic [1:0]             state_q;
   logic [BURST_CNT_W-1:0] burst_cnt_q;
   logic                   done_q;
   logic                   ctrl_wr;
   logic                   arm;
   logic [3:0]             cnt_sat;
   reg_data_t              status;

   assign ctrl_wr        = bus.write && (bus.addr == `ADDR_LA_CTRL);
   assign arm            = ctrl_wr & bus.wdata[`LA_ARM_BIT];
   assign fifo.clear_err = ctrl_wr & bus.wdata[`LA_CLEAR_BIT];
   assign fifo.flush     = ctrl_wr & bus.wdata[`LA_FLUSH_BIT];

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= ST_IDLE;
         burst_cnt_q <= '0;
         done_q      <= 1'b0;
      end else if (arm) begin        // re-arm restarts any burst
         state_q     <= ST_ARMED;
         burst_cnt_q <= '0;
         done_q      <= 1'b0;
      end else begin
         case (state_q)
            ST_ARMED: begin
               if (trig_i) state_q <= ST_CAPTURE;
            end
            ST_CAPTURE: begin
               if (burst_cnt_q == BURST_CNT_W'(`LA_BURST_LEN - 1)) begin
                  state_q     <= ST_IDLE;
                  burst_cnt_q <= '0;
                  done_q      <= 1'b1;
               end else begin
                  burst_cnt_q <= burst_cnt_q + 1'b1;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // one sample per capture cycle, no back-pressure
   assign fifo.wr      = (state_q == ST_CAPTURE);
   assign fifo.wr_data = la_sample_t'({trig_i, target_io_i});

   assign armed_o     = (state_q != ST_IDLE);
   assign capturing_o = (state_q == ST_CAPTURE);

   assign cnt_sat = (fifo.count > fifo_cnt_t'(15)) ? 4'hf : fifo.count[3:0];
   assign status  = {cnt_sat, fifo.error, fifo.empty, done_q, armed_o};
   assign rdata_o = (bus.addr == `ADDR_LA_STATUS) ? status : '0;

endmodule

//--- rtl/led_status.sv
`include "husky_lite_config.svh"

module led_status (
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic error_i,
   input  logic pll_status_i,
   input  logic armed_i,
   input  logic capturing_i,
   output logic led_adc_o,
   output logic led_armed_o,
   output logic led_cap_o
);

   logic [`FLASH_BIT:0] flash_cnt_q;   // free running

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flash_cnt_q <= '0;
         led_armed_o <= 1'b0;
         led_cap_o   <= 1'b0;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;
         led_armed_o <= armed_i;
         led_cap_o   <= capturing_i;
      end
   end

   // fast flash on a sticky fifo error, pll lock indication otherwise
   assign led_adc_o = error_i ? flash_cnt_q[`FLASH_BIT] : ~pll_status_i;

endmodule

//--- rtl/reg_bus_if.sv
interface reg_bus_if;
   import husky_lite_pkg::*;

   reg_addr_t addr;
   reg_data_t wdata;
   logic      read;    // single cycle pulse
   logic      write;   // single cycle pulse

   modport host (
      output addr,
      output wdata,
      output read,
      output write
   );

   modport device (
      input addr,
      input wdata,
      input read,
      input write
   );

endinterface

//--- rtl/trigger_ctrl.sv
`include "husky_lite_config.svh"

module trigger_ctrl (
   input  logic                        clk_usb_buf,
   input  logic                        rst_n_i,
   reg_bus_if.device                   bus,
   input  logic [`TARGET_IO_WIDTH-1:0] target_io_i,
   output husky_lite_pkg::reg_data_t   rdata_o,
   output logic                        trig_o,
   output logic                        target_poweron_o
);
   import husky_lite_pkg::*;

   logic [`TARGET_IO_WIDTH-1:0] mask_q;
   logic [`TARGET_IO_WIDTH-1:0] masked_io;
   logic                        and_mode_q;
   logic                        power_q;
   logic                        trig_next;
   reg_data_t                   cfg_word;
   reg_data_t                   pwr_word;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mask_q     <= '0;
         and_mode_q <= 1'b0;
         power_q    <= 1'b0;
         trig_o     <= 1'b0;
      end else begin
         if (bus.write && (bus.addr == `ADDR_TRIG_CFG)) begin
            mask_q     <= bus.wdata[`TARGET_IO_WIDTH-1:0];
            and_mode_q <= bus.wdata[`TRIG_MODE_BIT];
         end
         if (bus.write && (bus.addr == `ADDR_TARGET_PWR)) begin
            power_q <= bus.wdata[0];
         end
         trig_o <= trig_next;
      end
   end

   assign masked_io = target_io_i & mask_q;
   // an empty mask never fires, in either mode
   assign trig_next = and_mode_q ? ((mask_q != '0) && (masked_io == mask_q))
                                 : (masked_io != '0);

   always_comb begin
      cfg_word                         = '0;
      cfg_word[`TARGET_IO_WIDTH-1:0]   = mask_q;
      cfg_word[`TRIG_MODE_BIT]         = and_mode_q;
   end

   assign pwr_word = reg_data_t'(power_q);

   assign rdata_o = (bus.addr == `ADDR_TRIG_CFG)   ? cfg_word :
                    (bus.addr == `ADDR_TARGET_PWR) ? pwr_word : '0;

   assign target_poweron_o = power_q;

endmodule

//--- rtl/usb_reg_bus.sv
`include "husky_lite_config.svh"

module usb_reg_bus (
   input  logic                      clk_usb_buf,
   input  logic                      rst_n_i,
   input  husky_lite_pkg::reg_addr_t usb_addr_i,
   input  husky_lite_pkg::reg_data_t usb_data_i,
   input  logic                      usb_rdn_i,
   input  logic                      usb_wrn_i,
   input  logic                      usb_cen_i,
   output husky_lite_pkg::reg_data_t usb_data_o,
   output logic                      usb_data_oe_o,
   input  husky_lite_pkg::reg_data_t trig_rdata_i,
   input  husky_lite_pkg::reg_data_t la_rdata_i,
   reg_bus_if.host                   bus,
   capture_fifo_if.reader            fifo
);
   import husky_lite_pkg::*;

   logic      wr_act;
   logic      rd_act;
   logic      wr_act_q;
   logic      rd_act_q;
   logic      wr_start;
   logic      rd_start;
   logic      read_q;        // read pulse one cycle later
   logic      fifo_sel;
   reg_data_t or_rdata_q;
   reg_data_t rdata_q;

   assign wr_act   = ~usb_cen_i & ~usb_wrn_i;
   assign rd_act   = ~usb_cen_i & ~usb_rdn_i;
   assign wr_start = wr_act & ~wr_act_q;   // first cycle of the strobe
   assign rd_start = rd_act & ~rd_act_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_act_q  <= 1'b0;
         rd_act_q  <= 1'b0;
         bus.write <= 1'b0;
         bus.read  <= 1'b0;
         read_q    <= 1'b0;
      end else begin
         wr_act_q  <= wr_act;
         rd_act_q  <= rd_act;
         bus.write <= wr_start;
         bus.read  <= rd_start;
         read_q    <= bus.read;
      end
   end

   // address and data stay latched until the next strobe
   always_ff @(posedge clk_usb_buf) begin
      if (wr_start | rd_start) begin
         bus.addr  <= usb_addr_i;
         bus.wdata <= usb_data_i;
      end
   end

   assign fifo_sel = (bus.addr == `ADDR_FIFO_READ);
   assign fifo.pop = read_q & fifo_sel;

   // devices return zero outside their own addresses
   always_ff @(posedge clk_usb_buf) begin
      or_rdata_q <= trig_rdata_i | la_rdata_i;
      if (read_q) begin
         rdata_q <= fifo_sel ? fifo.head : or_rdata_q;
      end
   end

   assign usb_data_o    = rdata_q;
   assign usb_data_oe_o = rd_act;

endmodule
